// File: rtl/isa_pkg.sv
package isa_pkg;

  typedef logic [4:0] reg_addr_t;

  // major opcodes in use
  typedef enum logic [6:0] {
    OP    = 7'b0110011,  // reg-reg, also M extension
    OPIMM = 7'b0010011,
    LUI   = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    SLT = 4'd7   // signed compare
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL   = 2'd0,  // low word
    MULH  = 2'd1,  // high word, signed x signed
    MULHU = 2'd2   // high word, unsigned
  } mul_op_e;

  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

// File: rtl/core_pkg.sv
package core_pkg;

  import isa_pkg::*;

  typedef logic [3:0] rob_tag_t;  // up to 16 ROB entries

  typedef struct packed {
    logic        ready;
    rob_tag_t    tag;    // producer when not ready
    logic [31:0] value;
  } operand_t;

  typedef struct packed {
    rob_tag_t tag;  // destination ROB entry
    operand_t src1;
    operand_t src2;
  } dispatch_t;

  typedef struct packed {
    logic        valid;
    rob_tag_t    tag;
    logic [31:0] value;
  } cdb_t;

  typedef struct packed {
    logic        valid;
    rob_tag_t    tag;
    reg_addr_t   rd;
    logic [31:0] value;
  } commit_t;

endpackage

// File: rtl/issue_stage.sv
`timescale 1ns/1ns

module issue_stage import isa_pkg::*, core_pkg::*; (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic        o_inst_ready,
  input  logic        i_rob_ready,
  input  rob_tag_t    i_rob_tag,
  output rob_tag_t    o_src_tag1,
  output rob_tag_t    o_src_tag2,
  input  operand_t    i_src_op1,
  input  operand_t    i_src_op2,
  input  commit_t     i_commit,
  input  logic        i_alu_rs_ready,
  input  logic        i_mul_rs_ready,
  output dispatch_t   o_dispatch,
  output logic        o_alu_valid,
  output alu_op_e     o_alu_op,
  output logic        o_mul_valid,
  output mul_op_e     o_mul_op,
  output logic        o_rob_alloc,
  output reg_addr_t   o_rob_rd
);

  opcode_e     opcode;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  reg_addr_t   rd;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic        is_mul;
  logic        fire;

  logic [31:0] regs [32];
  logic [31:0] busy;       // register waits on a ROB entry
  rob_tag_t    tags [32];

  assign opcode = opcode_e'(i_inst[6:0]);
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign funct7 = i_inst[31:25];
  assign imm_i  = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_u  = {i_inst[31:12], 12'b0};
  assign is_mul = (opcode == OP) && (funct7 == F7_MULDIV);

  always_comb begin
    case (funct3)
      3'b000:  o_alu_op = (opcode == OP && funct7[5]) ? SUB : ADD;
      3'b001:  o_alu_op = SLL;
      3'b010:  o_alu_op = SLT;
      3'b100:  o_alu_op = XOR;
      3'b101:  o_alu_op = SRL;
      3'b110:  o_alu_op = OR;
      3'b111:  o_alu_op = AND;
      default: o_alu_op = ADD;
    endcase
    if (opcode == LUI) begin
      o_alu_op = ADD;  // 0 + upper immediate
    end
  end

  always_comb begin
    case (funct3)
      3'b001:  o_mul_op = MULH;
      3'b011:  o_mul_op = MULHU;
      default: o_mul_op = MUL;
    endcase
  end

  // register file, then ROB if renamed, else wait on the tag
  function automatic operand_t read_src(reg_addr_t r, logic [31:0] rf_val, logic rf_busy,
                                        rob_tag_t rf_tag, operand_t rob_op);
    operand_t o;
    o.ready = 1'b1;
    o.tag   = rf_tag;
    o.value = rf_val;
    if (r == '0) begin
      o.value = '0;  // x0
    end else if (rf_busy) begin
      o.ready = rob_op.ready;
      o.value = rob_op.value;
    end
    return o;
  endfunction

  assign o_src_tag1 = tags[rs1];
  assign o_src_tag2 = tags[rs2];

  always_comb begin
    o_dispatch.tag  = i_rob_tag;
    o_dispatch.src1 = read_src(rs1, regs[rs1], busy[rs1], tags[rs1], i_src_op1);
    o_dispatch.src2 = read_src(rs2, regs[rs2], busy[rs2], tags[rs2], i_src_op2);
    if (opcode == LUI) begin
      o_dispatch.src1 = '{ready: 1'b1, tag: '0, value: '0};
      o_dispatch.src2 = '{ready: 1'b1, tag: '0, value: imm_u};
    end else if (opcode == OPIMM) begin
      o_dispatch.src2 = '{ready: 1'b1, tag: '0, value: imm_i};
    end
  end

  assign o_inst_ready = i_rob_ready && (is_mul ? i_mul_rs_ready : i_alu_rs_ready);
  assign fire         = i_inst_valid && o_inst_ready;
  assign o_alu_valid  = fire && !is_mul;
  assign o_mul_valid  = fire && is_mul;
  assign o_rob_alloc  = fire;
  assign o_rob_rd     = rd;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else begin
      if (i_commit.valid && i_commit.rd != '0) begin
        regs[i_commit.rd] <= i_commit.value;
        if (busy[i_commit.rd] && tags[i_commit.rd] == i_commit.tag) begin
          busy[i_commit.rd] <= 1'b0;  // last writer retired
        end
      end
      if (fire && rd != '0) begin
        busy[rd] <= 1'b1;  // later assignment beats the commit clear
        tags[rd] <= i_rob_tag;
      end
    end
  end

endmodule

// File: rtl/reservation_station.sv
`timescale 1ns/1ns

module reservation_station import core_pkg::*; #(
  parameter type op_t     = logic [3:0],
  parameter int  RS_DEPTH = 2
) (
  input  logic                                   clk_100mhz,
  input  logic                                   sys_rst,
  input  logic                                   i_valid,
  input  op_t                                    i_op,
  input  dispatch_t                              i_dispatch,
  input  cdb_t                                   i_cdb,
  output logic                                   o_free,
  output logic                                   o_req_valid,
  input  logic                                   i_req_ready,
  output logic [$bits(op_t)+$bits(rob_tag_t)+63:0] o_req
);

  typedef struct packed {
    op_t         op;
    rob_tag_t    tag;
    logic [31:0] a;
    logic [31:0] b;
  } exec_req_t;

  localparam int IW = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  logic [RS_DEPTH-1:0] busy;
  op_t                 ops  [RS_DEPTH];
  dispatch_t           ents [RS_DEPTH];
  logic [IW-1:0]       free_idx;
  logic [IW-1:0]       req_idx;
  exec_req_t           req;

  // pick up a broadcast for an operand still waiting on its tag
  function automatic operand_t wake(operand_t o, cdb_t c);
    if (!o.ready && c.valid && c.tag == o.tag) begin
      o.ready = 1'b1;
      o.value = c.value;
    end
    return o;
  endfunction

  // scan downwards so the lowest index wins
  always_comb begin
    o_free      = 1'b0;
    free_idx    = '0;
    o_req_valid = 1'b0;
    req_idx     = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        o_free   = 1'b1;
        free_idx = IW'(i);
      end
      if (busy[i] && ents[i].src1.ready && ents[i].src2.ready) begin
        o_req_valid = 1'b1;
        req_idx     = IW'(i);
      end
    end
  end

  always_comb begin
    req = '{op:  ops[req_idx],
            tag: ents[req_idx].tag,
            a:   ents[req_idx].src1.value,
            b:   ents[req_idx].src2.value};
  end

  assign o_req = req;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (busy[i]) begin
          ents[i].src1 <= wake(ents[i].src1, i_cdb);
          ents[i].src2 <= wake(ents[i].src2, i_cdb);
        end
      end
      if (o_req_valid && i_req_ready) begin
        busy[req_idx] <= 1'b0;  // handed to the unit
      end
      if (i_valid) begin
        busy[free_idx] <= 1'b1;
        ops[free_idx]  <= i_op;
        ents[free_idx] <= '{tag:  i_dispatch.tag,
                            src1: wake(i_dispatch.src1, i_cdb),
                            src2: wake(i_dispatch.src2, i_cdb)};
      end
    end
  end

endmodule

// File: rtl/alu_unit.sv
`timescale 1ns/1ns

module alu_unit import isa_pkg::*, core_pkg::*; #(
  parameter type op_t = alu_op_e
) (
  input  logic                                   clk_100mhz,
  input  logic                                   sys_rst,
  input  logic                                   i_req_valid,
  output logic                                   o_req_ready,
  input  logic [$bits(op_t)+$bits(rob_tag_t)+63:0] i_req,
  output logic                                   o_res_valid,
  output cdb_t                                   o_res,
  input  logic                                   i_grant
);

  typedef struct packed {
    op_t         op;
    rob_tag_t    tag;
    logic [31:0] a;
    logic [31:0] b;
  } exec_req_t;

  exec_req_t   req;
  logic [31:0] result;
  cdb_t        res_q;  // held until the arbiter takes it

  assign req = i_req;

  always_comb begin
    case (req.op)
      ADD:     result = req.a + req.b;
      SUB:     result = req.a - req.b;
      AND:     result = req.a & req.b;
      OR:      result = req.a | req.b;
      XOR:     result = req.a ^ req.b;
      SLL:     result = req.a << req.b[4:0];
      SRL:     result = req.a >> req.b[4:0];
      SLT:     result = {31'b0, $signed(req.a) < $signed(req.b)};
      default: result = '0;
    endcase
  end

  assign o_req_ready = !res_q.valid || i_grant;
  assign o_res_valid = res_q.valid;
  assign o_res       = res_q;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      res_q.valid <= 1'b0;
    end else if (i_req_valid && o_req_ready) begin
      res_q <= '{valid: 1'b1, tag: req.tag, value: result};
    end else if (i_grant) begin
      res_q.valid <= 1'b0;
    end
  end

endmodule

// File: rtl/mul_unit.sv
`timescale 1ns/1ns

module mul_unit import isa_pkg::*, core_pkg::*; #(
  parameter type op_t       = mul_op_e,
  parameter int  MUL_STAGES = 3
) (
  input  logic                                   clk_100mhz,
  input  logic                                   sys_rst,
  input  logic                                   i_req_valid,
  output logic                                   o_req_ready,
  input  logic [$bits(op_t)+$bits(rob_tag_t)+63:0] i_req,
  output logic                                   o_res_valid,
  output cdb_t                                   o_res,
  input  logic                                   i_grant
);

  typedef struct packed {
    op_t         op;
    rob_tag_t    tag;
    logic [31:0] a;
    logic [31:0] b;
  } exec_req_t;

  typedef struct packed {
    logic        valid;
    op_t         op;
    rob_tag_t    tag;
    logic [63:0] prod;
  } stage_t;

  exec_req_t   req;
  stage_t      pipe [MUL_STAGES];
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic        advance;

  assign req = i_req;

  // only MULH needs signed operands, the low word is the same either way
  always_comb begin
    ext_a = {32'b0, req.a};
    ext_b = {32'b0, req.b};
    if (req.op == MULH) begin
      ext_a = {{32{req.a[31]}}, req.a};
      ext_b = {{32{req.b[31]}}, req.b};
    end
  end

  assign advance     = !pipe[MUL_STAGES-1].valid || i_grant;  // stall behind the last stage
  assign o_req_ready = advance;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int s = 0; s < MUL_STAGES; s++) begin
        pipe[s].valid <= 1'b0;
      end
    end else if (advance) begin
      pipe[0] <= '{valid: i_req_valid, op: req.op, tag: req.tag, prod: ext_a * ext_b};
      for (int s = 1; s < MUL_STAGES; s++) begin
        pipe[s] <= pipe[s-1];
      end
    end
  end

  assign o_res_valid = pipe[MUL_STAGES-1].valid;

  always_comb begin
    o_res.valid = pipe[MUL_STAGES-1].valid;
    o_res.tag   = pipe[MUL_STAGES-1].tag;
    o_res.value = (pipe[MUL_STAGES-1].op == MUL) ? pipe[MUL_STAGES-1].prod[31:0]
                                                 : pipe[MUL_STAGES-1].prod[63:32];
  end

endmodule

// File: rtl/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter import core_pkg::*; (
  input  logic clk_100mhz,
  input  logic sys_rst,
  input  logic i_alu_valid,
  input  cdb_t i_alu_res,
  input  logic i_mul_valid,
  input  cdb_t i_mul_res,
  output logic o_alu_grant,
  output logic o_mul_grant,
  output cdb_t o_cdb
);

  // fixed priority, ALU first
  assign o_alu_grant = i_alu_valid;
  assign o_mul_grant = i_mul_valid && !i_alu_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= o_alu_grant || o_mul_grant;
      if (o_alu_grant) begin
        o_cdb.tag   <= i_alu_res.tag;
        o_cdb.value <= i_alu_res.value;
      end else begin
        o_cdb.tag   <= i_mul_res.tag;
        o_cdb.value <= i_mul_res.value;
      end
    end
  end

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer import isa_pkg::*, core_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  logic      clk_100mhz,
  input  logic      sys_rst,
  input  logic      i_alloc,
  input  reg_addr_t i_rd,
  output logic      o_ready,
  output rob_tag_t  o_tag,
  input  rob_tag_t  i_src_tag1,
  input  rob_tag_t  i_src_tag2,
  output operand_t  o_src_op1,
  output operand_t  o_src_op2,
  input  cdb_t      i_cdb,
  output commit_t   o_commit
);

  localparam int PW = $clog2(ROB_DEPTH);

  logic [PW-1:0]        head;
  logic [PW-1:0]        tail;
  logic [PW:0]          count;
  logic [ROB_DEPTH-1:0] done;
  reg_addr_t            rds  [ROB_DEPTH];
  logic [31:0]          vals [ROB_DEPTH];
  logic                 retire;

  assign o_ready = (count != (PW+1)'(ROB_DEPTH));
  assign o_tag   = rob_tag_t'(tail);
  assign retire  = (count != '0) && done[head];

  // operand lookup for renamed sources
  always_comb begin
    o_src_op1 = '{ready: done[i_src_tag1[PW-1:0]],
                  tag:   i_src_tag1,
                  value: vals[i_src_tag1[PW-1:0]]};
    o_src_op2 = '{ready: done[i_src_tag2[PW-1:0]],
                  tag:   i_src_tag2,
                  value: vals[i_src_tag2[PW-1:0]]};
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      done           <= '0;
      o_commit.valid <= 1'b0;
    end else begin
      if (i_alloc) begin
        rds[tail]  <= i_rd;
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;  // wraps, depth is a power of two
      end
      if (i_cdb.valid) begin
        done[i_cdb.tag[PW-1:0]] <= 1'b1;
        vals[i_cdb.tag[PW-1:0]] <= i_cdb.value;
      end
      o_commit.valid <= retire;
      if (retire) begin
        o_commit.tag   <= rob_tag_t'(head);
        o_commit.rd    <= rds[head];
        o_commit.value <= vals[head];
        head           <= head + 1'b1;
      end
      count <= count + (PW+1)'(i_alloc) - (PW+1)'(retire);
    end
  end

endmodule

// File: rtl/ooo_core_top.sv
`timescale 1ns/1ns

module ooo_core_top import isa_pkg::*, core_pkg::*; #(
  parameter int ROB_DEPTH  = 8,
  parameter int RS_DEPTH   = 2,
  parameter int MUL_STAGES = 3
) (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic        o_inst_ready,
  output commit_t     o_commit
);

  localparam int ALU_REQ_W = $bits(alu_op_e) + $bits(rob_tag_t) + 64;
  localparam int MUL_REQ_W = $bits(mul_op_e) + $bits(rob_tag_t) + 64;

  // issue <-> ROB
  logic      rob_ready;
  rob_tag_t  rob_tag;
  rob_tag_t  src_tag1;
  rob_tag_t  src_tag2;
  operand_t  src_op1;
  operand_t  src_op2;
  logic      rob_alloc;
  reg_addr_t rob_rd;

  // issue -> stations
  dispatch_t dispatch;
  logic      alu_rs_valid;
  logic      mul_rs_valid;
  alu_op_e   alu_op;
  mul_op_e   mul_op;
  logic      alu_rs_free;
  logic      mul_rs_free;

  // stations -> units
  logic                 alu_req_valid;
  logic                 alu_req_ready;
  logic [ALU_REQ_W-1:0] alu_req;
  logic                 mul_req_valid;
  logic                 mul_req_ready;
  logic [MUL_REQ_W-1:0] mul_req;

  // units -> arbiter -> bus
  logic alu_res_valid;
  cdb_t alu_res;
  logic alu_grant;
  logic mul_res_valid;
  cdb_t mul_res;
  logic mul_grant;
  cdb_t cdb;

  issue_stage u_issue (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .o_inst_ready   (o_inst_ready),
    .i_rob_ready    (rob_ready),
    .i_rob_tag      (rob_tag),
    .o_src_tag1     (src_tag1),
    .o_src_tag2     (src_tag2),
    .i_src_op1      (src_op1),
    .i_src_op2      (src_op2),
    .i_commit       (o_commit),
    .i_alu_rs_ready (alu_rs_free),
    .i_mul_rs_ready (mul_rs_free),
    .o_dispatch     (dispatch),
    .o_alu_valid    (alu_rs_valid),
    .o_alu_op       (alu_op),
    .o_mul_valid    (mul_rs_valid),
    .o_mul_op       (mul_op),
    .o_rob_alloc    (rob_alloc),
    .o_rob_rd       (rob_rd)
  );

  reservation_station #(
    .op_t     (alu_op_e),
    .RS_DEPTH (RS_DEPTH)
  ) u_alu_rs (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_valid     (alu_rs_valid),
    .i_op        (alu_op),
    .i_dispatch  (dispatch),
    .i_cdb       (cdb),
    .o_free      (alu_rs_free),
    .o_req_valid (alu_req_valid),
    .i_req_ready (alu_req_ready),
    .o_req       (alu_req)
  );

  reservation_station #(
    .op_t     (mul_op_e),
    .RS_DEPTH (RS_DEPTH)
  ) u_mul_rs (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_valid     (mul_rs_valid),
    .i_op        (mul_op),
    .i_dispatch  (dispatch),
    .i_cdb       (cdb),
    .o_free      (mul_rs_free),
    .o_req_valid (mul_req_valid),
    .i_req_ready (mul_req_ready),
    .o_req       (mul_req)
  );

  alu_unit #(
    .op_t (alu_op_e)
  ) u_alu (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_req_valid (alu_req_valid),
    .o_req_ready (alu_req_ready),
    .i_req       (alu_req),
    .o_res_valid (alu_res_valid),
    .o_res       (alu_res),
    .i_grant     (alu_grant)
  );

  mul_unit #(
    .op_t       (mul_op_e),
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_req_valid (mul_req_valid),
    .o_req_ready (mul_req_ready),
    .i_req       (mul_req),
    .o_res_valid (mul_res_valid),
    .o_res       (mul_res),
    .i_grant     (mul_grant)
  );

  cdb_arbiter u_arb (
    .clk_100mhz  (clk_100mhz),
    .sys_rst     (sys_rst),
    .i_alu_valid (alu_res_valid),
    .i_alu_res   (alu_res),
    .i_mul_valid (mul_res_valid),
    .i_mul_res   (mul_res),
    .o_alu_grant (alu_grant),
    .o_mul_grant (mul_grant),
    .o_cdb       (cdb)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_alloc    (rob_alloc),
    .i_rd       (rob_rd),
    .o_ready    (rob_ready),
    .o_tag      (rob_tag),
    .i_src_tag1 (src_tag1),
    .i_src_tag2 (src_tag2),
    .o_src_op1  (src_op1),
    .o_src_op2  (src_op2),
    .i_cdb      (cdb),
    .o_commit   (o_commit)
  );

endmodule

// File: tb/ooo_core_checker.sv
`timescale 1ns/1ns

module ooo_core_checker import core_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input logic    clk_100mhz,
  input logic    sys_rst,
  input logic    i_inst_valid,
  input logic    i_inst_ready,
  input commit_t i_commit
);

  int       fail_count = 0;
  logic     started;   // first instruction taken
  int       pending;   // accepted, commit not seen yet
  rob_tag_t next_tag;  // tag the next commit must carry

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      started  <= 1'b0;
      pending  <= 0;
      next_tag <= '0;
    end else begin
      if (i_inst_valid && i_inst_ready) begin
        started <= 1'b1;
      end
      pending <= pending + int'(i_inst_valid && i_inst_ready) - int'(i_commit.valid);
      if (i_commit.valid) begin
        next_tag <= rob_tag_t'((int'(next_tag) + 1) % ROB_DEPTH);
      end
    end
  end

  // quiet and ready until the first instruction
  a_reset_idle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !started |-> !i_commit.valid && i_inst_ready)
    else begin
      fail_count++;
      $error("commit or stall seen before the first instruction");
    end

  a_commit_order: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_commit.valid |-> i_commit.tag == next_tag)
    else begin
      fail_count++;
      $error("commit tag out of program order");
    end

  // a commit seen now was retired one edge earlier
  a_full_stall: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (pending - int'(i_commit.valid)) >= ROB_DEPTH |-> !i_inst_ready)
    else begin
      fail_count++;
      $error("instruction ready with a full ROB");
    end

endmodule

bind ooo_core_top ooo_core_checker #(
  .ROB_DEPTH (ROB_DEPTH)
) u_checker (
  .clk_100mhz   (clk_100mhz),
  .sys_rst      (sys_rst),
  .i_inst_valid (i_inst_valid),
  .i_inst_ready (o_inst_ready),
  .i_commit     (o_commit)
);

// File: tb/ooo_core_tb.sv
`timescale 1ns/1ns

module ooo_core_tb import isa_pkg::*, core_pkg::*; ();

  localparam int ROB_DEPTH   = 8;
  localparam int MUL_STAGES  = 3;
  localparam int N_INST      = 265;  // all directed and random instructions
  localparam int WATCHDOG_NS = N_INST * (MUL_STAGES + ROB_DEPTH + 4) * 10 + 1000;

  typedef struct packed {
    reg_addr_t   rd;
    logic [31:0] value;
  } expect_t;

  logic        clk_100mhz;
  logic        sys_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_ready;
  commit_t     o_commit;

  expect_t     exp_q [$];        // accepted, not yet committed
  logic [31:0] model_regs [32];
  integer      seed = 80672;
  int          accepted;
  int          committed;
  int          value_errs;
  int          rd_errs;
  int          other_errs;
  int          total_errs;
  logic        stall_seen;

  ooo_core_top DUT (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_inst_ready (o_inst_ready),
    .o_commit     (o_commit)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: not every accepted instruction committed in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                         logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                         reg_addr_t rd);
    return {imm, rs1, f3, rd, OPIMM};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, LUI};
  endfunction

  // architectural result from the model registers
  function automatic logic [31:0] model_result(logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] prod;
    logic [2:0]  f3;
    a  = model_regs[inst[19:15]];
    b  = model_regs[inst[24:20]];
    f3 = inst[14:12];
    if (inst[6:0] == LUI) begin
      return {inst[31:12], 12'b0};
    end
    if (inst[6:0] == OPIMM) begin
      b = {{20{inst[31]}}, inst[31:20]};
    end
    if (inst[6:0] == OP && inst[31:25] == 7'h01) begin
      if (f3 == 3'd1) begin
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // mulh
      end else begin
        prod = {32'b0, a} * {32'b0, b};
      end
      return (f3 == 3'd0) ? prod[31:0] : prod[63:32];
    end
    case (f3)
      3'd0:    return (inst[6:0] == OP && inst[30]) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    r   = $random(seed);
    rd  = {2'b0, r[2:0]};  // few registers, many hazards
    rs1 = {2'b0, r[5:3]};
    rs2 = {2'b0, r[8:6]};
    f3  = (r[11:9] == 3'd3) ? 3'd0 : r[11:9];  // sltu not in the core
    imm = (f3 == 3'd1 || f3 == 3'd5) ? {7'b0, r[24:20]} : r[31:20];
    case (r[14:13])
      2'd0:    return r_type((f3 == 3'd0 && r[12]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      2'd1:    return i_type(imm, rs1, f3, rd);
      2'd2:    return r[12] ? u_type(r[31:12], rd) : i_type(r[31:20], rs1, 3'd0, rd);
      default: return r_type(7'h01, rs2, rs1, r[9] ? 3'd1 : (r[10] ? 3'd3 : 3'd0), rd);
    endcase
  endfunction

  // hold the instruction until the core takes it
  task automatic send(input logic [31:0] inst);
    logic    taken;
    expect_t e;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_100mhz);
      i_inst_valid = 1'b1;
      i_inst       = inst;
      #1;
      taken = o_inst_ready;  // stable until the next rising edge
      if (!taken) begin
        stall_seen = 1'b1;
      end
    end
    e.rd    = inst[11:7];
    e.value = model_result(inst);
    exp_q.push_back(e);
    if (inst[11:7] != 5'd0) begin
      model_regs[inst[11:7]] = e.value;
    end
    accepted++;
  endtask

  task automatic drain();
    @(negedge clk_100mhz);
    i_inst_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_100mhz);
    end
  endtask

  task automatic mul_with_younger_alu(input logic [2:0] f3);
    send(r_type(7'h01, 5'd2, 5'd1, f3, 5'd5));
    send(i_type(12'd9, 5'd0, 3'd0, 5'd6));
    send(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd7));
    send(i_type(12'h055, 5'd1, 3'd4, 5'd8));
  endtask

  task automatic fill_behind_mul_chain();
    repeat (3) send(r_type(7'h01, 5'd4, 5'd3, 3'd0, 5'd3));
    for (int i = 0; i < 10; i++) begin
      send(i_type(12'(i), 5'd0, 3'd0, 5'(9 + i % 4)));
    end
  endtask

  task automatic check_commit();
    expect_t e;
    committed++;
    assert (exp_q.size() != 0) else begin
      $display("commit at %0t with no accepted instruction outstanding", $time);
      other_errs++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      assert (o_commit.rd == e.rd) else begin
        $display("[ERROR] o_commit.rd expected %h got %h", e.rd, o_commit.rd);
        rd_errs++;
      end
      assert (o_commit.value == e.value) else begin
        $display("[ERROR] o_commit.value expected %h got %h", e.value, o_commit.value);
        value_errs++;
      end
    end
  endtask

  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit.valid) begin
      check_commit();
    end
  end

  initial begin
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    accepted     = 0;
    committed    = 0;
    value_errs   = 0;
    rd_errs      = 0;
    other_errs   = 0;
    stall_seen   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    sys_rst = 1'b0;
    repeat (4) @(negedge clk_100mhz);  // idle, checker watches the reset state

    send(u_type(20'h12345, 5'd1));
    send(i_type(12'hff9, 5'd0, 3'd0, 5'd2));   // -7
    send(u_type(20'h80000, 5'd3));
    drain();
    send(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
    send(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd5));
    send(r_type(7'h00, 5'd2, 5'd3, 3'd2, 5'd6));
    send(r_type(7'h00, 5'd1, 5'd2, 3'd7, 5'd7));
    send(r_type(7'h00, 5'd1, 5'd2, 3'd6, 5'd8));
    send(r_type(7'h00, 5'd1, 5'd2, 3'd4, 5'd9));
    send(i_type(12'h004, 5'd1, 3'd1, 5'd10));
    send(i_type(12'h008, 5'd3, 3'd5, 5'd11));
    send(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd12));
    send(i_type(12'h7ff, 5'd0, 3'd2, 5'd13));
    drain();

    // back-to-back dependent chain
    send(i_type(12'd1, 5'd0, 3'd0, 5'd1));
    repeat (5) send(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd1));
    send(r_type(7'h01, 5'd1, 5'd1, 3'd0, 5'd2));
    send(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
    send(r_type(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
    send(i_type(12'd5, 5'd4, 3'd0, 5'd0));     // result goes nowhere
    drain();

    send(i_type(12'hffd, 5'd0, 3'd0, 5'd1));
    send(u_type(20'h80001, 5'd2));
    mul_with_younger_alu(3'd0);
    mul_with_younger_alu(3'd1);
    mul_with_younger_alu(3'd3);
    drain();

    send(i_type(12'd3, 5'd0, 3'd0, 5'd3));
    send(i_type(12'd7, 5'd0, 3'd0, 5'd4));
    drain();
    stall_seen = 1'b0;
    fill_behind_mul_chain();
    fill_behind_mul_chain();
    drain();
    assert (stall_seen) else begin
      $display("o_inst_ready never dropped behind the multiply chain");
      other_errs++;
    end

    repeat (200) send(random_inst());
    drain();
    repeat (ROB_DEPTH + 4) @(negedge clk_100mhz);  // catch any late extra commit
    assert (committed == accepted) else begin
      $display("[ERROR] commit count expected %h got %h", accepted, committed);
      other_errs++;
    end

    total_errs = value_errs + rd_errs + other_errs + DUT.u_checker.fail_count;
    $display("errors: value %0d, rd %0d, other %0d, checker %0d (%0d commits)",
             value_errs, rd_errs, other_errs, DUT.u_checker.fail_count, committed);
    if (total_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/issue_stage.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/reorder_buffer.sv
rtl/ooo_core_top.sv
tb/ooo_core_checker.sv
tb/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb \
  -f files.f -o ooo_core_sim > build.log 2>&1 &&
  ./obj_dir/ooo_core_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
  echo "build or simulation returned an error status"
grep -q "TESTBENCH PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
